// ==== common/warp_params.svh ====
`ifndef WARP_PARAMS_SVH
`define WARP_PARAMS_SVH

// ####################################################################
// Address regions on the processor bus
// ####################################################################
`define RAM_TOP 2'b00        // A23..A22 for the DRAM region
`define ROM_PAGE 4'h4        // A23..A20 for the flash ROM
`define IACK_PAGE 16'hFFFF   // Interrupt acknowledge space

// ####################################################################
// Timing constants in FCLK cycles
// ####################################################################
`define RESET_CYCLES 16      // Length of the stretched reset
`define REF_SLOW 128         // Refresh interval with slow refresh
`define REF_FAST 64          // Refresh interval with fast refresh

`define ROM_WAIT0 2          // ROM access counts selected by sw[2:1]
`define ROM_WAIT1 3
`define ROM_WAIT2 4
`define ROM_WAIT3 6

`endif

// ==== common/warpPkg.sv ====
package warpPkg;

	// ####################################################################
	// Processor address A23..A1 and its two readings
	// ####################################################################
	typedef struct packed {
		logic [15:0] page;   // A23..A8 used by the region decoder
		logic [6:0] offset;  // A7..A1 inside the page
	} fsbDecS;

	typedef struct packed {
		logic [1:0] top;     // A23..A22 region bits
		logic [10:0] row;    // A21..A11 driven during RAS
		logic [9:0] col;     // A10..A1 driven during CAS
	} fsbDramS;

	typedef union packed {
		fsbDecS dec;         // View for chip select decode
		fsbDramS dram;       // View for the DRAM address mux
	} fsbAddrU;

	// One-hot select of the current bus cycle, all zero when idle
	typedef struct packed {
		logic ram;
		logic rom;
		logic io;
		logic iack;
	} selS;

	typedef struct packed {
		logic [2:0] romWait; // FCLK cycles until a ROM cycle ends
		logic refFast;       // Shorter refresh interval
	} cfgS;

	// Active high DRAM strobes, inverted at the pins
	typedef struct packed {
		logic ras;
		logic cas;
		logic lwe;
		logic uwe;
	} dramS;

	typedef logic [3:0][2:0] romWaitTblT; // Wait count per switch code

endpackage

// ==== hw/chipSelect.sv ====
`timescale 1ns/100ps
`include "warp_params.svh"

module chipSelect import warpPkg::*; (
	input logic FCLK,
	input logic arstN,
	input logic asN,
	input fsbAddrU addr,
	output logic busActive,
	output selS sel
);

	selS selNext; // Decoded region of the current address

	// ####################################################################
	// Region decode, iack has priority over the memory regions
	// ####################################################################
	always_comb begin
		selNext = '0;
		if (addr.dec.page == `IACK_PAGE) begin
			selNext.iack = 1'b1; // CPU space cycle
		end else if (addr.dec.page[15:14] == `RAM_TOP) begin
			selNext.ram = 1'b1; // Lowest 4 MB go to DRAM
		end else if (addr.dec.page[15:12] == `ROM_PAGE) begin
			selNext.rom = 1'b1;
		end else begin
			selNext.io = 1'b1; // Everything else goes to the peripheral side
		end
	end

	always_ff @(posedge FCLK or negedge arstN) begin
		if (!arstN) begin
			busActive <= 1'b0;
			sel <= '0;
		end else begin
			busActive <= !asN; // Follows AS one cycle late
			if (asN) begin
				sel <= '0; // Cleared together with busActive
			end else if (!busActive) begin
				sel <= selNext; // Captured on the first cycle of AS
			end
		end
	end

endmodule

// ==== hw/busTerm.sv ====
`timescale 1ns/100ps
`include "warp_params.svh"

module busTerm import warpPkg::*; (
	input logic FCLK,
	input logic arstN,
	input logic busActive,
	input logic ramReady,
	input logic ioDone,
	input selS sel,
	input cfgS cfg,
	output logic dtackN,
	output logic vpaN
);

	logic [2:0] waitCnt; // Cycles since busActive rose
	logic romRdy;        // ROM wait count reached
	logic ramRdy;
	logic ioRdy;
	logic anyRdy;        // Some source is ready to end the cycle

	// ####################################################################
	// Ready sources
	// ####################################################################
	always_comb begin
		romRdy = sel.rom && (waitCnt >= cfg.romWait - 3'd1);
		ramRdy = sel.ram && ramReady; // DRAM has reached CAS
		ioRdy = sel.io && ioDone;     // Single cycle pulse from the I/O side
		anyRdy = romRdy || ramRdy || ioRdy;
	end

	// ####################################################################
	// Termination registers
	// ####################################################################
	always_ff @(posedge FCLK or negedge arstN) begin
		if (!arstN) begin
			waitCnt <= '0;
			dtackN <= 1'b1;
			vpaN <= 1'b1;
		end else if (!busActive) begin
			waitCnt <= '0; // Ready for the next cycle
			dtackN <= 1'b1;
			vpaN <= 1'b1;
		end else begin
			if (waitCnt != 3'b111) begin
				waitCnt <= waitCnt + 3'd1; // Saturates on long cycles
			end
			if (anyRdy) begin
				dtackN <= 1'b0; // Held low until AS is released
			end
			if (sel.iack) begin
				vpaN <= 1'b0; // Autovector acknowledge
			end
		end
	end

endmodule

// ==== ram/ramCtrl.sv ====
`timescale 1ns/100ps
`include "warp_params.svh"

module ramCtrl import warpPkg::*; (
	input logic FCLK,
	input logic arstN,
	input logic busActive,
	input logic weN,
	input logic ldsN,
	input logic udsN,
	input logic refReq,
	input logic refUrg,
	input fsbAddrU addr,
	input selS sel,
	output logic ramReady,
	output logic refAck,
	output logic oeN,
	output logic romCsN,
	output logic [11:0] ra,
	output dramS dram
);

	typedef enum logic [2:0] {
		stIdle,
		stRow,
		stCol,
		stAccess,
		stRefresh,
		stRecover
	} stateT;

	stateT state;
	logic [1:0] refCnt; // Position inside the refresh burst
	logic ramGo;        // Access wins arbitration this cycle

	// Access goes first unless the refresh has become urgent
	assign ramGo = sel.ram && !(refReq && refUrg);

	// ####################################################################
	// Sequencer
	// ####################################################################
	always_ff @(posedge FCLK or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			refCnt <= '0;
			dram <= '0;
			ramReady <= 1'b0;
			refAck <= 1'b0;
		end else begin
			refAck <= 1'b0; // Single cycle pulse
			case (state)
				stIdle: begin
					if (ramGo) begin
						state <= stRow;
						dram.ras <= 1'b1; // Row already on ra
					end else if (refReq) begin
						state <= stRefresh;
						dram.cas <= 1'b1; // CAS before RAS
						refCnt <= '0;
						refAck <= 1'b1;
					end
				end
				stRow: state <= stCol; // ra turns to the column here
				stCol: begin
					state <= stAccess;
					dram.cas <= 1'b1;
					dram.lwe <= !weN && !ldsN; // Lane strobes only on writes
					dram.uwe <= !weN && !udsN;
					ramReady <= 1'b1;
				end
				stAccess: begin
					if (!busActive) begin
						state <= stIdle; // Processor has released AS
						dram <= '0;
						ramReady <= 1'b0;
					end
				end
				stRefresh: begin
					refCnt <= refCnt + 2'd1;
					if (refCnt == 2'd0) begin
						dram.ras <= 1'b1;
					end else if (refCnt == 2'd2) begin
						state <= stRecover;
						dram <= '0; // RAS precharge follows
					end
				end
				default: state <= stIdle; // Recover is one idle cycle
			endcase
		end
	end

	// Row is loaded while idle, column one cycle after RAS
	always_ff @(posedge FCLK) begin
		if (state == stIdle) begin
			ra <= {1'b0, addr.dram.row};
		end else if (state == stRow) begin
			ra <= {2'b00, addr.dram.col};
		end
	end

	// ####################################################################
	// Flash ROM controls
	// ####################################################################
	assign romCsN = !sel.rom;
	assign oeN = !(sel.rom && weN); // Read only from the flash
endmodule

// ==== hw/refreshTimer.sv ====
`timescale 1ns/100ps
`include "warp_params.svh"

module refreshTimer import warpPkg::*; (
	input logic FCLK,
	input logic arstN,
	input logic refAck,
	input cfgS cfg,
	output logic refReq,
	output logic refUrg,
	output logic resOutN
);

	localparam int refW = $clog2(`REF_SLOW);
	localparam int resW = $clog2(`RESET_CYCLES);

	logic [refW-1:0] refCnt;  // Interval down counter
	logic [refW-1:0] reload;  // Next interval minus one
	logic expire;
	logic [resW-1:0] resCnt;  // Reset stretch counter

	assign reload = cfg.refFast ? refW'(`REF_FAST - 1) : refW'(`REF_SLOW - 1);
	assign expire = (refCnt == '0);

	// ####################################################################
	// Refresh interval and request levels
	// ####################################################################
	always_ff @(posedge FCLK or negedge arstN) begin
		if (!arstN) begin
			refCnt <= refW'(`REF_SLOW - 1);
			refReq <= 1'b0;
			refUrg <= 1'b0;
		end else begin
			refCnt <= expire ? reload : refCnt - refW'(1);
			if (expire) begin
				refReq <= 1'b1;
			end else if (refAck) begin
				refReq <= 1'b0; // Controller has started the burst
			end
			if (expire && refReq && !refAck) begin
				refUrg <= 1'b1; // A whole interval was missed
			end else if (refAck) begin
				refUrg <= 1'b0;
			end
		end
	end

	// ####################################################################
	// Stretched reset output
	// ####################################################################
	always_ff @(posedge FCLK or negedge arstN) begin
		if (!arstN) begin
			resCnt <= '0;
			resOutN <= 1'b0;
		end else if (!resOutN) begin
			resCnt <= resCnt + resW'(1);
			if (resCnt == resW'(`RESET_CYCLES - 1)) begin
				resOutN <= 1'b1; // Released after the last count
			end
		end
	end

endmodule

// ==== hw/speedCfg.sv ====
`timescale 1ns/100ps
`include "warp_params.svh"

module speedCfg import warpPkg::*; (
	input logic FCLK,
	input logic arstN,
	input logic busActive,
	input logic [3:1] sw,
	output cfgS cfg
);

	// Index 3 is the slowest ROM setting
	localparam romWaitTblT waitTbl = '{
		3'(`ROM_WAIT3),
		3'(`ROM_WAIT2),
		3'(`ROM_WAIT1),
		3'(`ROM_WAIT0)
	};

	always_ff @(posedge FCLK or negedge arstN) begin
		if (!arstN) begin
			cfg.romWait <= waitTbl[3]; // Safe until the switches are read
			cfg.refFast <= 1'b0;
		end else if (!busActive) begin
			cfg.romWait <= waitTbl[sw[2:1]]; // Never changes inside a cycle
			cfg.refFast <= sw[3];
		end
	end

endmodule

// ==== hw/warpTop.sv ====
`timescale 1ns/100ps
`include "warp_params.svh"

module warpTop import warpPkg::*; (
	input logic FCLK,
	input logic arstN,
	input logic asN,
	input logic ldsN,
	input logic udsN,
	input logic weN,
	input logic ioDone,
	input fsbAddrU addr,
	input logic [3:1] sw,
	output logic dtackN,
	output logic vpaN,
	output logic ioSel,
	output logic rasN,
	output logic casN,
	output logic ramLweN,
	output logic ramUweN,
	output logic oeN,
	output logic romCsN,
	output logic resOutN,
	output logic [11:0] ra
);

	logic busActive;      // Processor cycle in progress
	selS sel;
	cfgS cfg;
	logic refReq, refUrg; // Refresh levels toward the DRAM controller
	logic refAck;
	logic ramReady;
	dramS dram;

	// ####################################################################
	// Blocks
	// ####################################################################
	chipSelect cs (.FCLK, .arstN, .asN, .addr, .busActive, .sel);

	speedCfg cfgReg (.FCLK, .arstN, .busActive, .sw, .cfg);

	refreshTimer refTmr (.FCLK, .arstN, .refAck, .cfg, .refReq, .refUrg, .resOutN);

	ramCtrl ram (
		.FCLK, .arstN, .busActive, .weN, .ldsN, .udsN, .refReq, .refUrg,
		.addr, .sel, .ramReady, .refAck, .oeN, .romCsN, .ra, .dram
	);

	busTerm term (
		.FCLK, .arstN, .busActive, .ramReady, .ioDone, .sel, .cfg,
		.dtackN, .vpaN
	);

	// Pins are active low
	assign rasN = !dram.ras;
	assign casN = !dram.cas;
	assign ramLweN = !dram.lwe;
	assign ramUweN = !dram.uwe;
	assign ioSel = sel.io;

endmodule

// ==== dv/warpTb.sv ====
`timescale 1ns/100ps
`include "warp_params.svh"

module warpTb;

	// Bus cycles issued by all tests together
	localparam int busCount = 27;
	localparam int cycleMax = `ROM_WAIT3 + 2 * 5 + 10; // Longest bus cycle with two refresh bursts
	localparam int cycleLimit = busCount * cycleMax + 9 * `REF_SLOW + `RESET_CYCLES + 50;

	logic FCLK;
	logic arstN;
	logic asN;
	logic ldsN;
	logic udsN;
	logic weN;
	logic ioDone;
	logic [22:0] addr;   // A23..A1
	logic [3:1] sw;
	logic dtackN;
	logic vpaN;
	logic ioSel;
	logic rasN;
	logic casN;
	logic ramLweN;
	logic ramUweN;
	logic oeN;
	logic romCsN;
	logic resOutN;
	logic [11:0] ra;

	logic [31:0] seed;
	int cycles;          // Clock edges since time zero
	int errors;
	int checks;
	int nTests;
	int errMark;         // Error count when the current test began

	warpTop uut (
		.FCLK, .arstN, .asN, .ldsN, .udsN, .weN, .ioDone, .addr, .sw,
		.dtackN, .vpaN, .ioSel, .rasN, .casN, .ramLweN, .ramUweN, .oeN, .romCsN,
		.resOutN, .ra
	);

	initial begin
		FCLK = 1'b0;
		forever #20 FCLK = ~FCLK;
	end

	always @(posedge FCLK) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("tests failed");
			$finish;
		end
	end

	// ####################################################################
	// Bus rules that hold in every cycle
	// ####################################################################
	assert property (@(posedge FCLK) disable iff (!arstN) !(!dtackN && !vpaN))
		else begin
			errors = errors + 1;
			$display("dtackN and vpaN were low together");
		end

	assert property (@(posedge FCLK) disable iff (!arstN) !oeN |-> !romCsN)
		else begin
			errors = errors + 1;
			$display("flash output enable without chip select");
		end

	assert property (@(posedge FCLK) disable iff (!arstN) (!ramLweN || !ramUweN) |-> !casN)
		else begin
			errors = errors + 1;
			$display("DRAM write strobe without column strobe");
		end

	// ####################################################################
	// Helpers
	// ####################################################################
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic nextCycle(); // Outputs settled, inputs may change
		@(posedge FCLK);
		#2;
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks = checks + 1;
		assert (got === exp) else begin
			errors = errors + 1;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks = checks + 1;
		assert (got === exp) else begin
			errors = errors + 1;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checks = checks + 1;
		assert (cond) else begin
			errors = errors + 1;
			$display("%s", what);
		end
	endtask

	task automatic finishTest(input string name);
		nTests = nTests + 1;
		$display("%s %s, %0d errors", name, (errors == errMark) ? "ok" : "FAILED", errors - errMark);
		errMark = errors;
	endtask

	task automatic setSwitch(input logic [1:0] code, input logic fast);
		sw = {fast, code};
		nextCycle(); // Taken in while the bus is idle
		nextCycle();
	endtask

	// ####################################################################
	// Processor bus cycles
	// ####################################################################
	task automatic startCycle(input logic [22:0] a, input logic wr, input logic [1:0] lanes);
		addr = a;
		weN = !wr;
		ldsN = !lanes[0]; // Lane bit 0 is the low byte
		udsN = !lanes[1];
		asN = 1'b0;
	endtask

	task automatic endCycle(input logic isRam);
		asN = 1'b1;
		nextCycle(); // busActive drops on this edge
		nextCycle();
		checkBit("dtackN", dtackN, 1'b1);
		checkBit("vpaN", vpaN, 1'b1);
		checkBit("romCsN", romCsN, 1'b1);
		checkBit("oeN", oeN, 1'b1);
		checkBit("ioSel", ioSel, 1'b0);
		if (isRam) begin
			checkBit("rasN", rasN, 1'b1);
			checkBit("casN", casN, 1'b1);
			checkBit("ramLweN", ramLweN, 1'b1);
			checkBit("ramUweN", ramUweN, 1'b1);
		end
		weN = 1'b1;
		ldsN = 1'b1;
		udsN = 1'b1;
		nextCycle();
	endtask

	task automatic ramCycle(input logic [22:0] a, input logic wr, input logic [1:0] lanes);
		logic prevRasN;
		logic rasSeen;
		logic colPending;
		logic casSeen;
		logic [11:0] rowExp;
		logic [11:0] colExp;
		rowExp = {1'b0, a[20:10]}; // A21..A11
		colExp = {2'b00, a[9:0]};  // A10..A1
		rasSeen = 1'b0;
		colPending = 1'b0;
		casSeen = 1'b0;
		prevRasN = rasN;
		startCycle(a, wr, lanes);
		nextCycle();
		while (dtackN) begin
			if (colPending) begin
				checkEq("ra", 32'(ra), 32'(colExp));
				checkBit("casN", casN, 1'b1);
				colPending = 1'b0;
			end
			// An access opens with RAS while CAS is still high
			if (!rasN && prevRasN && casN) begin
				rasSeen = 1'b1;
				colPending = 1'b1;
				checkEq("ra", 32'(ra), 32'(rowExp));
			end
			if (!casN && rasSeen && !casSeen) begin
				casSeen = 1'b1;
				checkBit("rasN", rasN, 1'b0);
				checkBit("ramLweN", ramLweN, !(wr && lanes[0]));
				checkBit("ramUweN", ramUweN, !(wr && lanes[1]));
			end
			prevRasN = rasN;
			nextCycle();
		end
		checkTrue(casSeen && !casN, "dtackN fell before the DRAM column strobe");
		endCycle(1'b1);
	endtask

	task automatic romCycle(input logic [1:0] code, input logic wr);
		logic [22:0] a;
		int k;
		int waitExp;
		case (code)
			2'd0: waitExp = `ROM_WAIT0;
			2'd1: waitExp = `ROM_WAIT1;
			2'd2: waitExp = `ROM_WAIT2;
			default: waitExp = `ROM_WAIT3;
		endcase
		seed = xorshift(seed);
		a = {4'h4, seed[18:0]};
		startCycle(a, wr, 2'b11);
		nextCycle();
		k = 1;
		checkBit("busActive", uut.busActive, 1'b1); // First cycle of the access
		while (dtackN) begin
			checkBit("romCsN", romCsN, 1'b0);
			checkBit("oeN", oeN, wr); // Output enable only on reads
			nextCycle();
			k = k + 1;
		end
		checkEq("ROM wait", k - 1, waitExp);
		endCycle(1'b0);
	endtask

	task automatic ioCycle(input int delay);
		logic [22:0] a;
		seed = xorshift(seed);
		a = {4'h8, seed[18:0]};
		startCycle(a, seed[20], 2'b11);
		nextCycle();
		checkBit("ioSel", ioSel, 1'b1);
		for (int i = 0; i < delay; i++) begin
			checkBit("dtackN", dtackN, 1'b1); // Must not end before ioDone
			nextCycle();
		end
		checkBit("dtackN", dtackN, 1'b1);
		ioDone = 1'b1;
		nextCycle();
		checkBit("dtackN", dtackN, 1'b0);
		ioDone = 1'b0;
		endCycle(1'b0);
	endtask

	task automatic iackCycle();
		seed = xorshift(seed);
		startCycle({16'hFFFF, seed[6:0]}, 1'b0, 2'b01);
		nextCycle();
		checkBit("vpaN", vpaN, 1'b1);
		nextCycle();
		checkBit("vpaN", vpaN, 1'b0);
		repeat (3) begin
			checkBit("dtackN", dtackN, 1'b1); // Autovector, never DTACK
			nextCycle();
		end
		endCycle(1'b0);
	endtask

	// ####################################################################
	// Refresh observer
	// ####################################################################
	task automatic waitRefresh(output int at);
		logic prevCasN;
		prevCasN = casN;
		nextCycle();
		while (!(!casN && prevCasN && rasN)) begin
			prevCasN = casN;
			nextCycle();
		end
		at = cycles; // CAS fell while RAS stayed high
	endtask

	task automatic checkRefresh();
		repeat (2) begin
			nextCycle();
			checkBit("rasN", rasN, 1'b0);
			checkBit("casN", casN, 1'b0);
			checkBit("ramReady", uut.ramReady, 1'b0);
		end
		nextCycle();
		checkBit("rasN", rasN, 1'b1);
		checkBit("casN", casN, 1'b1);
	endtask

	// ####################################################################
	// Test sequence
	// ####################################################################
	initial begin
		logic [22:0] a;
		logic wr;
		logic [1:0] lanes;
		int n;
		int t0;
		int t1;
		int t2;
		arstN = 1'b0;
		asN = 1'b1;
		ldsN = 1'b1;
		udsN = 1'b1;
		weN = 1'b1;
		ioDone = 1'b0;
		addr = '0;
		sw = 3'b011;
		seed = 32'he9f0_261f;
		cycles = 0;
		errors = 0;
		checks = 0;
		nTests = 0;
		errMark = 0;

		repeat (3) @(posedge FCLK);
		#2;
		checkBit("dtackN", dtackN, 1'b1);
		checkBit("vpaN", vpaN, 1'b1);
		checkBit("romCsN", romCsN, 1'b1);
		checkBit("oeN", oeN, 1'b1);
		checkBit("rasN", rasN, 1'b1);
		checkBit("casN", casN, 1'b1);
		checkBit("resOutN", resOutN, 1'b0);
		arstN = 1'b1;
		n = 0;
		while (!resOutN) begin
			nextCycle();
			n = n + 1;
		end
		checkEq("resOutN delay", n, `RESET_CYCLES);
		finishTest("reset");

		for (int i = 0; i < 12; i++) begin
			seed = xorshift(seed);
			a = seed[22:0];
			a[22:21] = 2'b00; // Keep it inside the DRAM region
			wr = seed[23];
			lanes = wr ? seed[25:24] : 2'b11;
			if (lanes == 2'b00) begin
				lanes = 2'b01;
			end
			ramCycle(a, wr, lanes);
		end
		finishTest("ram");

		for (int c = 0; c < 4; c++) begin
			seed = xorshift(seed);
			setSwitch(2'(c), seed[0]);
			romCycle(2'(c), 1'b0);
			romCycle(2'(c), 1'b1);
		end
		finishTest("rom");

		for (int i = 0; i < 4; i++) begin
			seed = xorshift(seed);
			ioCycle(32'(seed[2:0]));
		end
		finishTest("io");

		iackCycle();
		iackCycle();
		finishTest("iack");

		for (int f = 1; f >= 0; f--) begin
			seed = xorshift(seed);
			setSwitch(seed[1:0], f[0]);
			waitRefresh(t0); // May still use the old interval
			checkRefresh();
			waitRefresh(t1);
			checkRefresh();
			waitRefresh(t2);
			checkRefresh();
			checkEq("refresh interval", t2 - t1, (f == 1) ? `REF_FAST : `REF_SLOW);
		end
		waitRefresh(t0);
		seed = xorshift(seed);
		a = seed[22:0];
		a[22:21] = 2'b00;
		ramCycle(a, 1'b1, 2'b11); // Issued while the burst is running
		finishTest("refresh");

		$display("%0d tests, %0d checks, %0d errors", nTests, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+common
common/warpPkg.sv
hw/chipSelect.sv
hw/busTerm.sv
ram/ramCtrl.sv
hw/refreshTimer.sv
hw/speedCfg.sv
hw/warpTop.sv
dv/warpTb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
		--top-module warpTb -Mdir obj_dir -o warpSim
	@out="$$(./obj_dir/warpSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
